/* tb.f */
rtl/simd_isa_pkg.sv
rtl/simd_timing_pkg.sv
rtl/simd_decode.sv
rtl/simd_score_board.sv
rtl/simd_exec_pipe.sv
rtl/simd_result.sv
rtl/simd_issue_top.sv
verification/tb_simd_issue.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vector issue testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_simd_issue -f tb.f -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

/* verification/tb_simd_issue.sv */
// Testbench for the vector issue block with directed timing cases and a random mix against a model
`default_nettype none

module tb_simd_issue;

    localparam int VLEN    = 128;
    localparam int RED_D   = $clog2(VLEN / 8);  // Reduction tree depth
    localparam int MAX_LAT = RED_D + 1;
    localparam int TMO     = 40;                 // Cycle limit of every wait loop

    logic        clk_i;
    logic        rstn_i;
    logic        valid_i;
    logic [31:0] instr_i;
    logic        flush_i;
    logic        stall_o;
    logic        wb_valid_o;
    logic [4:0]  wb_vd_o;
    logic [1:0]  sew_o;

    // Model of write port use, counted in edges from now
    logic        m_v  [0:MAX_LAT+1];
    logic [4:0]  m_vd [0:MAX_LAT+1];
    logic [31:0] m_pending;
    logic [1:0]  m_sew;
    logic        last_stall;
    logic        last_issue;
    logic [31:0] rng;

    simd_issue_top #(.VLEN(VLEN)) i_simd_issue_top (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .valid_i    (valid_i),
        .instr_i    (instr_i),
        .flush_i    (flush_i),
        .stall_o    (stall_o),
        .wb_valid_o (wb_valid_o),
        .wb_vd_o    (wb_vd_o),
        .sew_o      (sew_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] arith_word(input logic [5:0] f6, input logic [2:0] f3,
                                               input logic [4:0] vs2, input logic [4:0] vs1,
                                               input logic [4:0] vd);
        return {f6, 1'b1, vs2, vs1, f3, vd, 7'b1010111};
    endfunction

    function automatic logic [31:0] cfg_word(input logic [2:0] vsew);
        return {6'b0, vsew, 3'b0, 5'd0, 3'b111, 5'd0, 7'b1010111};  // vsetvli x0, x0
    endfunction

    // One word per class with sources v20 and v21
    function automatic logic [31:0] class_word(input logic [1:0] cls, input logic [4:0] vd);
        case (cls)
            simd_isa_pkg::CLS_MUL:  return arith_word(6'b100101, 3'b010, 5'd20, 5'd21, vd);
            simd_isa_pkg::CLS_MACC: return arith_word(6'b101101, 3'b010, 5'd20, 5'd21, vd);
            simd_isa_pkg::CLS_RED:  return arith_word(6'b000000, 3'b010, 5'd20, 5'd21, vd);
            default:                return arith_word(6'b000000, 3'b000, 5'd20, 5'd21, vd);
        endcase
    endfunction

    function automatic logic [1:0] model_class(input logic [31:0] w);
        logic [5:0] f6;
        f6 = w[31:26];
        if (w[14:12] != 3'b010) return simd_isa_pkg::CLS_ALU;
        if (f6[5:3] == 3'b000) return simd_isa_pkg::CLS_RED;
        if (f6[5:2] == 4'b1001 || f6 == 6'b111000 || f6 == 6'b111010 || f6 == 6'b111011)
            return simd_isa_pkg::CLS_MUL;
        if (f6[5:3] == 3'b101 && f6[0]) return simd_isa_pkg::CLS_MACC;
        return simd_isa_pkg::CLS_ALU;
    endfunction

    function automatic int model_lat(input logic [1:0] cls, input logic [1:0] sew);
        case (cls)
            simd_isa_pkg::CLS_MUL:  return (sew == 2'd3) ? 3 : 2;
            simd_isa_pkg::CLS_MACC: return (sew == 2'd3) ? 4 : 3;
            simd_isa_pkg::CLS_RED:  return (sew < 2'd2) ? RED_D + 1
                                         : (sew == 2'd2) ? RED_D : RED_D - 1;
            default:                return 1;
        endcase
    endfunction

    function automatic logic [31:0] rand_word(input logic [31:0] r);
        logic [5:0] f6;
        case (r[13:12])
            2'd0:    f6 = {3'b000, r[16:14]};        // Reductions
            2'd1:    f6 = {4'b1001, r[15:14]};       // Multiplies
            2'd2:    f6 = {3'b101, r[15:14], 1'b1};  // Multiply-accumulate
            default: f6 = r[19:14];
        endcase
        case (r[9:8])
            2'd0:    return cfg_word({r[12] & r[13], r[11:10]});  // Some vsew illegal
            2'd1:    return {r[31:7], 7'b0110011};               // Not OP-V
            default: return arith_word(f6, r[10] ? 3'b010 : 3'b000, {2'b0, r[22:20]},
                                       {2'b0, r[25:23]}, {2'b0, r[28:26]});
        endcase
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopping on a timeout");
    endtask

    // Drive one cycle, compare mid-cycle, then advance the model across the edge
    task automatic step(input logic v, input logic [31:0] w, input logic f);
        logic arith;
        int   lat;
        logic stall_exp;
        valid_i = v;
        instr_i = w;
        flush_i = f;
        #2;
        arith     = v && (w[6:0] == 7'b1010111) && (w[14:12] != 3'b111);
        lat       = model_lat(model_class(w), m_sew);
        stall_exp = arith && (m_v[lat+1] || m_pending[w[19:15]] || m_pending[w[24:20]]
                              || m_pending[w[11:7]]);
        check_val("stall_o", 32'(stall_o), 32'(stall_exp));
        check_val("wb_valid_o", 32'(wb_valid_o), 32'(m_v[0]));
        if (m_v[0]) check_val("wb_vd_o", 32'(wb_vd_o), 32'(m_vd[0]));
        check_val("sew_o", 32'(sew_o), 32'(m_sew));
        last_stall = stall_exp;
        last_issue = arith && !stall_exp && !f;
        if (m_v[1]) m_pending[m_vd[1]] = 1'b0;  // Freed as the write port fires
        for (int k = 0; k <= MAX_LAT; k++) begin
            m_v[k]  = m_v[k+1];
            m_vd[k] = m_vd[k+1];
        end
        m_v[MAX_LAT+1] = 1'b0;
        if (last_issue) begin
            m_v[lat]           = 1'b1;
            m_vd[lat]          = w[11:7];
            m_pending[w[11:7]] = 1'b1;
        end
        if (f) begin
            for (int k = 0; k <= MAX_LAT + 1; k++) m_v[k] = 1'b0;
            m_pending = '0;
        end
        if (v && (w[6:0] == 7'b1010111) && (w[14:12] == 3'b111) && !w[25]) m_sew = w[24:23];
        @(posedge clk_i);
        #1;
    endtask

    task automatic issue_word(input logic [31:0] w, output int stalls);
        stalls = 0;
        step(1'b1, w, 1'b0);
        while (!last_issue) begin
            stalls++;
            if (stalls > TMO) fail_plain("Timeout: a held word was never issued");
            step(1'b1, w, 1'b0);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (m_pending != '0 || m_v[0]) begin
            n++;
            if (n > TMO) fail_plain("Timeout: pipeline did not drain");
            step(1'b0, 32'd0, 1'b0);
        end
    endtask

    task automatic measure_latency(input logic [31:0] w, input int exp_lat);
        int stalls;
        int n;
        issue_word(w, stalls);
        n = 0;
        while (!wb_valid_o) begin
            n++;
            if (n > TMO) fail_plain("Timeout: no writeback after issue");
            step(1'b0, 32'd0, 1'b0);
        end
        check_val("latency", 32'(n), 32'(exp_lat));
        check_val("writeback vd", 32'(wb_vd_o), 32'(w[11:7]));
    endtask

    initial begin
        int          stalls;
        logic [31:0] w;
        logic [31:0] held;
        logic [31:0] ctl;
        rstn_i    = 1'b0;
        valid_i   = 1'b0;
        instr_i   = 32'd0;
        flush_i   = 1'b0;
        rng       = 32'd22590;
        m_pending = '0;
        m_sew     = simd_isa_pkg::SEW_8;
        for (int k = 0; k <= MAX_LAT + 1; k++) m_v[k] = 1'b0;
        last_stall = 1'b0;
        last_issue = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        // Every class at every SEW
        for (int s = 0; s < 4; s++) begin
            step(1'b1, cfg_word({1'b0, 2'(s)}), 1'b0);
            check_val("sew after config", 32'(sew_o), 32'(s));
            for (int c = 0; c < 4; c++)
                measure_latency(class_word(2'(c), 5'(c + 1)), model_lat(2'(c), 2'(s)));
            drain();
        end

        // SEW change steers the next latency and an illegal vsew is ignored
        step(1'b1, cfg_word(3'b010), 1'b0);
        step(1'b1, cfg_word(3'b101), 1'b0);
        check_val("sew after illegal vsew", 32'(sew_o), 32'(simd_isa_pkg::SEW_32));
        measure_latency(class_word(simd_isa_pkg::CLS_RED, 5'd7), RED_D);
        step(1'b1, cfg_word(3'b000), 1'b0);
        measure_latency(class_word(simd_isa_pkg::CLS_RED, 5'd7), RED_D + 1);

        // Writeback slot collision of a MACC and a MUL one cycle later
        issue_word(class_word(simd_isa_pkg::CLS_MACC, 5'd1), stalls);
        issue_word(class_word(simd_isa_pkg::CLS_MUL, 5'd2), stalls);
        check_val("collision stall cycles", 32'(stalls), 32'd1);
        drain();

        // Read and write hazards on pending registers
        issue_word(class_word(simd_isa_pkg::CLS_RED, 5'd3), stalls);
        issue_word(arith_word(6'b000000, 3'b000, 5'd9, 5'd3, 5'd4), stalls);
        check_val("read hazard stall cycles", 32'(stalls), 32'(RED_D + 1));
        issue_word(class_word(simd_isa_pkg::CLS_MUL, 5'd5), stalls);
        issue_word(arith_word(6'b000000, 3'b000, 5'd9, 5'd9, 5'd5), stalls);
        check_val("write hazard stall cycles", 32'(stalls), 32'd2);
        drain();

        // Flush while two are in flight and a dependent word waits
        issue_word(class_word(simd_isa_pkg::CLS_RED, 5'd8), stalls);
        issue_word(class_word(simd_isa_pkg::CLS_MACC, 5'd9), stalls);
        w = arith_word(6'b000000, 3'b000, 5'd8, 5'd9, 5'd10);
        step(1'b1, w, 1'b0);
        check_val("stall before flush", 32'(last_stall), 32'd1);
        step(1'b1, w, 1'b1);
        step(1'b1, w, 1'b0);
        check_val("issue after flush", 32'(last_issue), 32'd1);
        repeat (MAX_LAT + 2) step(1'b0, 32'd0, 1'b0);

        // Random mix where the source holds a stalled word
        held = 32'd0;
        for (int i = 0; i < 2000; i++) begin
            rng = xorshift32(rng);
            if (!last_stall) held = rand_word(rng);
            rng = xorshift32(rng);
            ctl = rng;
            step(ctl[2:0] != 3'd0, held, ctl[8:4] == 5'd0);
        end
        drain();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/simd_issue_top.sv */
// Vector issue top: decode, score board, execute pipe and result stage
`default_nettype none

module simd_issue_top #(
    parameter int VLEN = 128  // Power of two, 64 to 1024
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        valid_i,
    input  logic [31:0] instr_i,
    input  logic        flush_i,
    output logic        stall_o,
    output logic        wb_valid_o,
    output logic [4:0]  wb_vd_o,
    output logic [1:0]  sew_o
);

    localparam int MAX_LAT = simd_timing_pkg::red_depth(VLEN) + 1;
    localparam int LAT_W   = $clog2(MAX_LAT + 1);

    logic               is_cfg;
    logic               is_vec;
    logic [1:0]         instr_class;
    logic [4:0]         vs1;
    logic [4:0]         vs2;
    logic [4:0]         dec_vd;
    logic               issue;
    logic [LAT_W-1:0]   lat;
    logic [4:0]         issue_vd;
    logic [MAX_LAT-1:0] slot_busy;
    logic               pipe_wb_valid;
    logic [4:0]         pipe_wb_vd;
    logic [31:0]        pending;

    simd_decode u_decode (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .valid_i  (valid_i),
        .instr_i  (instr_i),
        .is_cfg_o (is_cfg),
        .is_vec_o (is_vec),
        .class_o  (instr_class),
        .vs1_o    (vs1),
        .vs2_o    (vs2),
        .vd_o     (dec_vd),
        .sew_o    (sew_o)
    );

    simd_score_board #(.VLEN(VLEN)) u_score_board (
        .valid_i     (valid_i),
        .flush_i     (flush_i),
        .is_cfg_i    (is_cfg),
        .is_vec_i    (is_vec),
        .class_i     (instr_class),
        .sew_i       (sew_o),
        .vs1_i       (vs1),
        .vs2_i       (vs2),
        .vd_i        (dec_vd),
        .slot_busy_i (slot_busy),
        .pending_i   (pending),
        .issue_o     (issue),
        .lat_o       (lat),
        .vd_o        (issue_vd),
        .stall_o     (stall_o)
    );

    simd_exec_pipe #(.VLEN(VLEN)) u_exec_pipe (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .issue_i     (issue),
        .lat_i       (lat),
        .vd_i        (issue_vd),
        .slot_busy_o (slot_busy),
        .wb_valid_o  (pipe_wb_valid),
        .wb_vd_o     (pipe_wb_vd)
    );

    simd_result u_result (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .flush_i    (flush_i),
        .issue_i    (issue),
        .issue_vd_i (issue_vd),
        .wb_valid_i (pipe_wb_valid),
        .wb_vd_i    (pipe_wb_vd),
        .pending_o  (pending),
        .wb_valid_o (wb_valid_o),
        .wb_vd_o    (wb_vd_o)
    );

endmodule

`default_nettype wire

/* rtl/simd_result.sv */
// Vector result stage: registered write port and pending destination set
`default_nettype none

module simd_result (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        flush_i,
    input  logic        issue_i,
    input  logic [4:0]  issue_vd_i,
    input  logic        wb_valid_i,
    input  logic [4:0]  wb_vd_i,
    output logic [31:0] pending_o,
    output logic        wb_valid_o,
    output logic [4:0]  wb_vd_o
);

    logic [31:0] pending_q;
    logic        wb_valid_q;
    logic [4:0]  wb_vd_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q  <= '0;
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= wb_valid_i && !flush_i;  // A flushed tag never reaches the port
            if (flush_i) begin
                pending_q <= '0;
            end else begin
                if (wb_valid_i) pending_q[wb_vd_i] <= 1'b0;
                if (issue_i) pending_q[issue_vd_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        wb_vd_q <= wb_vd_i;
    end

    assign pending_o  = pending_q;
    assign wb_valid_o = wb_valid_q;
    assign wb_vd_o    = wb_vd_q;

    a_wb_was_pending : assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_valid_i |-> pending_q[wb_vd_i]);

endmodule

`default_nettype wire

/* rtl/simd_exec_pipe.sv */
// Vector execute pipe: countdown slots carrying destination tags to writeback
`default_nettype none

module simd_exec_pipe #(
    parameter  int VLEN    = 128,
    localparam int MAX_LAT = simd_timing_pkg::red_depth(VLEN) + 1,
    localparam int LAT_W   = $clog2(MAX_LAT + 1)
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               flush_i,
    input  logic               issue_i,
    input  logic [LAT_W-1:0]   lat_i,
    input  logic [4:0]         vd_i,
    output logic [MAX_LAT-1:0] slot_busy_o,
    output logic               wb_valid_o,
    output logic [4:0]         wb_vd_o
);

    logic [MAX_LAT-1:0]      valid_q;
    logic [MAX_LAT-1:0]      valid_d;
    logic [MAX_LAT-1:0][4:0] vd_q;
    logic [MAX_LAT-1:0][4:0] vd_d;
    logic [MAX_LAT:0]        busy_ext;

    always_comb begin
        valid_d = flush_i ? '0 : (valid_q >> 1);  // Slot k becomes slot k-1
        vd_d    = {vd_q[MAX_LAT-1], vd_q[MAX_LAT-1:1]};
        for (int k = 0; k < MAX_LAT; k++) begin
            if (issue_i && (lat_i == LAT_W'(k + 1))) begin
                valid_d[k] = 1'b1;
                vd_d[k]    = vd_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        vd_q <= vd_d;  // Tags only matter where valid
    end

    assign slot_busy_o = valid_q;
    assign wb_valid_o  = valid_q[0];
    assign wb_vd_o     = vd_q[0];

    // Score board must never send a tag into a slot that the shift fills
    assign busy_ext = {1'b0, valid_q};
    a_no_slot_clash : assert property (@(posedge clk_i) disable iff (!rstn_i)
        issue_i |-> (lat_i != '0) && (lat_i <= LAT_W'(MAX_LAT)) && !busy_ext[lat_i]);

endmodule

`default_nettype wire

/* rtl/simd_score_board.sv */
// Vector score board choosing latency per class and SEW and stalling on slot or register hazards
`default_nettype none

module simd_score_board #(
    parameter  int VLEN    = 128,
    localparam int MAX_LAT = simd_timing_pkg::red_depth(VLEN) + 1,
    localparam int LAT_W   = $clog2(MAX_LAT + 1)
) (
    input  logic               valid_i,
    input  logic               flush_i,
    input  logic               is_cfg_i,
    input  logic               is_vec_i,
    input  logic [1:0]         class_i,
    input  logic [1:0]         sew_i,
    input  logic [4:0]         vs1_i,
    input  logic [4:0]         vs2_i,
    input  logic [4:0]         vd_i,
    input  logic [MAX_LAT-1:0] slot_busy_i,
    input  logic [31:0]        pending_i,
    output logic               issue_o,
    output logic [LAT_W-1:0]   lat_o,
    output logic [4:0]         vd_o,
    output logic               stall_o
);

    localparam int RED_DEPTH = simd_timing_pkg::red_depth(VLEN);

    logic             sew64;
    logic             arith_vld;
    logic [MAX_LAT:0] slot_ext;
    logic             slot_hit;
    logic             reg_hit;

    assign sew64 = (sew_i == simd_isa_pkg::SEW_64);

    always_comb begin
        case (class_i)
            simd_isa_pkg::CLS_MUL: begin
                lat_o = sew64 ? LAT_W'(simd_timing_pkg::LAT_MUL64)
                              : LAT_W'(simd_timing_pkg::LAT_MUL);
            end
            simd_isa_pkg::CLS_MACC: begin
                lat_o = sew64 ? LAT_W'(simd_timing_pkg::LAT_MACC64)
                              : LAT_W'(simd_timing_pkg::LAT_MACC);
            end
            simd_isa_pkg::CLS_RED: begin
                case (sew_i)
                    simd_isa_pkg::SEW_32: lat_o = LAT_W'(RED_DEPTH);
                    simd_isa_pkg::SEW_64: lat_o = LAT_W'(RED_DEPTH - 1);
                    default:              lat_o = LAT_W'(RED_DEPTH + 1);  // SEW 8 and 16
                endcase
            end
            default: lat_o = LAT_W'(simd_timing_pkg::LAT_ALU);
        endcase
    end

    assign arith_vld = valid_i && is_vec_i && !is_cfg_i;

    // Slot lat moves into lat-1 at the edge, where the new tag would land
    assign slot_ext = {1'b0, slot_busy_i};
    assign slot_hit = slot_ext[lat_o];

    assign reg_hit = pending_i[vs1_i] || pending_i[vs2_i] || pending_i[vd_i];

    always_comb begin
        stall_o = arith_vld && (slot_hit || reg_hit);
        issue_o = arith_vld && !stall_o && !flush_i;
    end

    assign vd_o = vd_i;

endmodule

`default_nettype wire

/* rtl/simd_decode.sv */
// Vector decode: SEW register from vsetvli and class/register fields of arithmetic words
`default_nettype none

module simd_decode (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        valid_i,
    input  logic [31:0] instr_i,
    output logic        is_cfg_o,
    output logic        is_vec_o,
    output logic [1:0]  class_o,
    output logic [4:0]  vs1_o,
    output logic [4:0]  vs2_o,
    output logic [4:0]  vd_o,
    output logic [1:0]  sew_o
);

    simd_isa_pkg::instr_word_u word;
    logic                      sew_load;
    logic [1:0]                sew_q;

    assign word = instr_i;

    assign is_vec_o = (word.arith.opcode == simd_isa_pkg::OPC_OP_V);
    assign is_cfg_o = is_vec_o && (word.cfg.funct3 == simd_isa_pkg::F3_OPCFG);

    // vsew[2] set is reserved, keep the old SEW then
    assign sew_load = valid_i && is_cfg_o && !word.cfg.zimm[5];

    always_comb begin
        class_o = simd_isa_pkg::CLS_ALU;  // Everything outside OPMVV
        if (word.arith.funct3 == simd_isa_pkg::F3_OPMVV) begin
            case (word.arith.funct6)
                simd_isa_pkg::F6_VMADD,
                simd_isa_pkg::F6_VNMSUB,
                simd_isa_pkg::F6_VMACC,
                simd_isa_pkg::F6_VNMSAC:   class_o = simd_isa_pkg::CLS_MACC;
                simd_isa_pkg::F6_VMUL,
                simd_isa_pkg::F6_VMULH,
                simd_isa_pkg::F6_VMULHU,
                simd_isa_pkg::F6_VMULHSU,
                simd_isa_pkg::F6_VWMUL,
                simd_isa_pkg::F6_VWMULU,
                simd_isa_pkg::F6_VWMULSU:  class_o = simd_isa_pkg::CLS_MUL;
                simd_isa_pkg::F6_VREDSUM,
                simd_isa_pkg::F6_VREDAND,
                simd_isa_pkg::F6_VREDOR,
                simd_isa_pkg::F6_VREDXOR,
                simd_isa_pkg::F6_VREDMINU,
                simd_isa_pkg::F6_VREDMIN,
                simd_isa_pkg::F6_VREDMAXU,
                simd_isa_pkg::F6_VREDMAX:  class_o = simd_isa_pkg::CLS_RED;
                default:                   class_o = simd_isa_pkg::CLS_ALU;
            endcase
        end
    end

    assign vs1_o = word.arith.vs1;
    assign vs2_o = word.arith.vs2;
    assign vd_o  = word.arith.vd;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sew_q <= simd_isa_pkg::SEW_8;
        end else if (sew_load) begin
            sew_q <= word.cfg.zimm[4:3];
        end
    end

    assign sew_o = sew_q;

endmodule

`default_nettype wire

/* rtl/simd_timing_pkg.sv */
// Vector unit timing: fixed latencies per class and reduction tree depth
`default_nettype none

package simd_timing_pkg;

    localparam int LAT_ALU = 1;

    localparam int LAT_MUL   = 2;
    localparam int LAT_MUL64 = 3;  // Extra stage for 64-bit products

    localparam int LAT_MACC   = 3;
    localparam int LAT_MACC64 = 4;

    // Adder tree levels over VLEN/8 byte lanes
    // Reductions take depth+1 at SEW 8/16, depth at 32, depth-1 at 64
    function automatic int red_depth(input int vlen);
        return $clog2(vlen / 8);
    endfunction

endpackage

`default_nettype wire

/* rtl/simd_isa_pkg.sv */
// Vector ISA encodings for the issue block: opcode, funct groups, class and SEW codes
`default_nettype none

package simd_isa_pkg;

    localparam logic [6:0] OPC_OP_V = 7'b1010111;  // Major opcode of all vector words

    localparam logic [2:0] F3_OPMVV = 3'b010;      // Mul, MAC and reduction group
    localparam logic [2:0] F3_OPCFG = 3'b111;      // vsetvli

    // Multiply-accumulate
    localparam logic [5:0] F6_VMADD   = 6'b101001;
    localparam logic [5:0] F6_VNMSUB  = 6'b101011;
    localparam logic [5:0] F6_VMACC   = 6'b101101;
    localparam logic [5:0] F6_VNMSAC  = 6'b101111;

    // Multiplies, widening ones included
    localparam logic [5:0] F6_VMULHU  = 6'b100100;
    localparam logic [5:0] F6_VMUL    = 6'b100101;
    localparam logic [5:0] F6_VMULHSU = 6'b100110;
    localparam logic [5:0] F6_VMULH   = 6'b100111;
    localparam logic [5:0] F6_VWMULU  = 6'b111000;
    localparam logic [5:0] F6_VWMULSU = 6'b111010;
    localparam logic [5:0] F6_VWMUL   = 6'b111011;

    // Reductions
    localparam logic [5:0] F6_VREDSUM  = 6'b000000;
    localparam logic [5:0] F6_VREDAND  = 6'b000001;
    localparam logic [5:0] F6_VREDOR   = 6'b000010;
    localparam logic [5:0] F6_VREDXOR  = 6'b000011;
    localparam logic [5:0] F6_VREDMINU = 6'b000100;
    localparam logic [5:0] F6_VREDMIN  = 6'b000101;
    localparam logic [5:0] F6_VREDMAXU = 6'b000110;
    localparam logic [5:0] F6_VREDMAX  = 6'b000111;

    localparam logic [1:0] CLS_ALU  = 2'd0;
    localparam logic [1:0] CLS_MUL  = 2'd1;
    localparam logic [1:0] CLS_MACC = 2'd2;
    localparam logic [1:0] CLS_RED  = 2'd3;

    localparam logic [1:0] SEW_8  = 2'd0;
    localparam logic [1:0] SEW_16 = 2'd1;
    localparam logic [1:0] SEW_32 = 2'd2;
    localparam logic [1:0] SEW_64 = 2'd3;

    // Same 32 bits seen as an arithmetic word or as a vsetvli word
    typedef union packed {
        struct packed {
            logic [5:0] funct6;
            logic       vm;
            logic [4:0] vs2;
            logic [4:0] vs1;
            logic [2:0] funct3;
            logic [4:0] vd;
            logic [6:0] opcode;
        } arith;
        struct packed {
            logic [11:0] zimm;  // vsew sits in zimm[5:3]
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } cfg;
    } instr_word_u;

endpackage

`default_nettype wire
